// ==== sdio_data_control.f ====
+incdir+tb
src/sdio_data_pkg.sv
src/sdio_xfer_config.sv
src/sdio_xfer_sequencer.sv
src/sdio_func_router.sv
src/sdio_data_control.sv
tb/tb_sdio_data_control.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_sdio_data_control
FILELIST  = sdio_data_control.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/sdio_target_model.svh ====
`ifndef SDIO_TARGET_MODEL_SVH
`define SDIO_TARGET_MODEL_SVH

// one planned transfer of the random run
typedef struct packed {
  logic              is_read;
  logic              blk;
  logic              cancel;
  logic              inc;
  logic              mem;
  logic [2:0]        func;
  logic [CNT_W-1:0]  cnt;
  logic [ADDR_W-1:0] addr;
} xfer_plan_t;

// a zero count stands for 512 bytes or 512 blocks
function automatic int count_value(input logic [CNT_W-1:0] cnt);
  if (cnt == '0) begin
    return BLOCK_BYTES;
  end
  return int'(cnt);
endfunction

function automatic int bytes_in_xfer(input xfer_plan_t p);
  if (p.blk) begin
    return count_value(p.cnt) * BLOCK_BYTES;
  end
  return count_value(p.cnt);
endfunction

// memory select wins over the function number
function automatic int target_of(input xfer_plan_t p);
  if (p.mem) begin
    return MEM_TARGET;
  end
  return int'(p.func);
endfunction

// address after nbytes, wraps at 2^18
function automatic logic [ADDR_W-1:0] final_address(input xfer_plan_t p, input int nbytes);
  if (p.inc) begin
    return p.addr + ADDR_W'(nbytes);
  end
  return p.addr;
endfunction

// next cycle of all nine targets
task automatic drive_targets(input logic read_mode, input int hold_rdy, output int rd_tgt);
  rd_tgt = -1;
  for (int i = 0; i < NUM_TARGETS; i++) begin
    func_up[i].rd_stb  = 1'b0;
    func_up[i].rd_data = BYTE_W'($urandom);
    // a target taking a write keeps its card ready level
    if (i != hold_rdy) begin
      func_up[i].com_rdy = ($urandom_range(0, 3) != 0);
    end
    // reads only while host ready is high
    if (read_mode && func_down[i].hst_rdy && $urandom_range(0, 3) != 0) begin
      func_up[i].rd_stb = 1'b1;
      rd_tgt = i;
    end
  end
endtask

`endif

// ==== tb/tb_sdio_data_control.sv ====
`timescale 1ns/1ps

module tb_sdio_data_control
  import sdio_data_pkg::*;
();

  logic               sdio_clk = 1'b0;
  logic               rst;
  logic               i_activate;
  logic               i_block_mode;
  logic               i_inc_addr;
  logic [ADDR_W-1:0]  i_cmd_address;
  logic [CNT_W-1:0]   i_data_cnt;
  logic [2:0]         i_func_sel;
  logic               i_mem_sel;
  logic               i_phy_wr_stb;
  logic [BYTE_W-1:0]  i_phy_wr_data;
  logic               o_phy_rd_stb;
  logic [BYTE_W-1:0]  o_phy_rd_data;
  logic               o_phy_com_rdy;
  func_down_t         func_down [NUM_TARGETS];
  func_up_t           func_up [NUM_TARGETS];
  logic [ADDR_W-1:0]  o_address;
  logic [TOTAL_W-1:0] o_total_data_cnt;
  logic               o_finished;

  int errors = 0;
  int test_errors = 0;
  int tests_failed = 0;
  int watchdog_cycles = 0;

  `include "sdio_target_model.svh"

  xfer_plan_t plans [$];

  sdio_data_control uut (
    .sdio_clk         (sdio_clk),
    .rst              (rst),
    .i_activate       (i_activate),
    .i_block_mode     (i_block_mode),
    .i_inc_addr       (i_inc_addr),
    .i_cmd_address    (i_cmd_address),
    .i_data_cnt       (i_data_cnt),
    .i_func_sel       (i_func_sel),
    .i_mem_sel        (i_mem_sel),
    .i_phy_wr_stb     (i_phy_wr_stb),
    .i_phy_wr_data    (i_phy_wr_data),
    .o_phy_rd_stb     (o_phy_rd_stb),
    .o_phy_rd_data    (o_phy_rd_data),
    .o_phy_com_rdy    (o_phy_com_rdy),
    .o_func_down      (func_down),
    .i_func_up        (func_up),
    .o_address        (o_address),
    .o_total_data_cnt (o_total_data_cnt),
    .o_finished       (o_finished)
  );

  always #10 sdio_clk = ~sdio_clk;

  task automatic report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  // only the selected target may see anything
  task automatic check_other_targets(input int tgt);
    for (int i = 0; i < NUM_TARGETS; i++) begin
      if (i != tgt && func_down[i] != '0) begin
        report_error($sformatf("target %0d not idle, selected is %0d", i, tgt));
      end
    end
  endtask

  function automatic string xfer_kind(input xfer_plan_t p);
    string s;
    s = p.is_read ? "read" : "write";
    s = p.blk ? {"block ", s} : {"byte ", s};
    if (p.cancel) begin
      s = {s, " cancelled"};
    end
    return s;
  endfunction

  task automatic finish_test(input int n, input string kind);
    if (test_errors == 0) begin
      $display("test %0d %s: ok", n, kind);
    end else begin
      $display("test %0d %s: %0d errors", n, kind, test_errors);
      tests_failed++;
    end
  endtask

  task automatic run_transfer(input xfer_plan_t p);
    int tgt;
    int nbytes;
    int done;
    int cut;
    int rd_tgt;
    int waited;
    logic wr;
    logic blk_end;
    logic [BYTE_W-1:0] wdata;
    tgt = target_of(p);
    nbytes = bytes_in_xfer(p);
    cut = p.cancel ? int'($urandom_range(1, nbytes - 1)) : -1;
    done = 0;
    blk_end = 1'b0;
    @(negedge sdio_clk);
    i_activate    = 1'b1;
    i_block_mode  = p.blk;
    i_inc_addr    = p.inc;
    i_cmd_address = p.addr;
    i_data_cnt    = p.cnt;
    i_func_sel    = p.func;
    i_mem_sel     = p.mem;
    while (done < nbytes && done != cut) begin
      @(negedge sdio_clk);
      if (o_finished) begin
        report_error($sformatf("o_finished high after %0d of %0d bytes", done, nbytes));
      end
      // first cycle after a full block that is not the last
      if (blk_end) begin
        if (func_down[tgt].hst_rdy || o_phy_com_rdy) begin
          report_error("data ready high between blocks");
        end
        if (o_total_data_cnt != TOTAL_W'(BLOCK_BYTES)) begin
          report_error($sformatf("o_total_data_cnt is %0d in block mode", o_total_data_cnt));
        end
        blk_end = 1'b0;
      end
      wr = !p.is_read && o_phy_com_rdy && ($urandom_range(0, 3) != 0);
      wdata = BYTE_W'($urandom);
      i_phy_wr_stb  = wr;
      i_phy_wr_data = wdata;
      drive_targets(p.is_read, wr ? tgt : -1, rd_tgt);
      #1;
      check_other_targets(tgt);
      if (!func_down[tgt].activate) begin
        report_error("activate not routed to the selected target");
      end
      // card ready of the selected target gated by data ready
      if (o_phy_com_rdy !== (func_up[tgt].com_rdy && func_down[tgt].hst_rdy)) begin
        report_error($sformatf("o_phy_com_rdy %0b, target ready %0b, data ready %0b",
                               o_phy_com_rdy, func_up[tgt].com_rdy,
                               func_down[tgt].hst_rdy));
      end
      if (func_down[tgt].wr_stb !== wr || (wr && func_down[tgt].wr_data !== wdata)) begin
        report_error($sformatf("write byte %0d not seen on target %0d", done, tgt));
      end
      if (rd_tgt >= 0 && rd_tgt != tgt) begin
        report_error($sformatf("target %0d read while not selected", rd_tgt));
      end
      if (o_phy_rd_stb !== (rd_tgt >= 0)) begin
        report_error("o_phy_rd_stb does not follow the target read strobe");
      end else if (rd_tgt >= 0 && o_phy_rd_data !== func_up[rd_tgt].rd_data) begin
        report_error($sformatf("o_phy_rd_data %02h, target sent %02h",
                               o_phy_rd_data, func_up[rd_tgt].rd_data));
      end
      if (wr || rd_tgt >= 0) begin
        done++;
        blk_end = p.blk && (done % BLOCK_BYTES == 0) && (done < nbytes);
      end
    end
    @(negedge sdio_clk);
    i_phy_wr_stb = 1'b0;
    drive_targets(1'b0, -1, rd_tgt);
    if (!p.cancel) begin
      waited = 0;
      while (!o_finished && waited < 3) begin
        if (func_down[tgt].hst_rdy) begin
          report_error("data ready high after the last byte");
        end
        @(negedge sdio_clk);
        waited++;
      end
      if (!o_finished) begin
        $display("o_finished did not rise within three cycles of the last byte");
        errors++;
        test_errors++;
      end
      if (o_address != final_address(p, nbytes)) begin
        report_error($sformatf("o_address %05h, expected %05h",
                               o_address, final_address(p, nbytes)));
      end
      if (o_total_data_cnt != TOTAL_W'(p.blk ? BLOCK_BYTES : count_value(p.cnt))) begin
        report_error($sformatf("o_total_data_cnt is %0d", o_total_data_cnt));
      end
      @(negedge sdio_clk);
    end
    // activate low ends or cancels the transfer
    i_activate = 1'b0;
    #1;
    for (int i = 0; i < NUM_TARGETS; i++) begin
      if (func_down[i].activate) begin
        report_error($sformatf("target %0d still active after activate dropped", i));
      end
    end
    @(negedge sdio_clk);
    if (o_finished) begin
      report_error("o_finished still high one cycle after activate dropped");
    end
  endtask

  initial begin
    xfer_plan_t p;
    int total;
    void'($urandom(15));
    rst           = 1'b1;
    i_activate    = 1'b0;
    i_block_mode  = 1'b0;
    i_inc_addr    = 1'b0;
    i_cmd_address = '0;
    i_data_cnt    = '0;
    i_func_sel    = '0;
    i_mem_sel     = 1'b0;
    i_phy_wr_stb  = 1'b0;
    i_phy_wr_data = '0;
    for (int i = 0; i < NUM_TARGETS; i++) begin
      func_up[i] = '0;
    end

    // byte transfers, two block transfers, then a cancel and one after it
    total = 0;
    for (int k = 0; k < 16; k++) begin
      p = '0;
      p.is_read = k[0];
      p.inc     = ($urandom_range(0, 3) != 0);
      p.mem     = ($urandom_range(0, 3) == 0);
      p.func    = 3'($urandom);
      p.addr    = ADDR_W'($urandom);
      p.cnt     = ($urandom_range(0, 5) == 0) ? '0 : CNT_W'($urandom_range(1, 48));
      if (k == 1) begin
        p.addr = '1;
      end
      if (k == 4) begin
        p.cnt = '0;
      end
      if (k == 12 || k == 13) begin
        p.blk = 1'b1;
        p.cnt = CNT_W'($urandom_range(1, 3));
      end
      if (k == 14) begin
        p.cancel = 1'b1;
        p.cnt    = CNT_W'($urandom_range(8, 48));
      end
      plans.push_back(p);
      total += bytes_in_xfer(p);
    end
    watchdog_cycles = total * 8 + plans.size() * 40 + 200;

    repeat (4) @(negedge sdio_clk);
    rst = 1'b0;
    check_other_targets(-1);
    if (o_phy_rd_stb || o_phy_com_rdy || o_finished) begin
      report_error("strobe or level high after reset");
    end
    if (o_address != '0) begin
      report_error($sformatf("o_address %05h after reset", o_address));
    end
    finish_test(0, "reset");

    for (int k = 0; k < plans.size(); k++) begin
      test_errors = 0;
      run_transfer(plans[k]);
      finish_test(k + 1, xfer_kind(plans[k]));
    end

    $display("tests %0d, failed %0d, errors %0d", plans.size() + 1, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // sized from the bytes planned over all transfers
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge sdio_clk);
    $display("timeout, the transfers did not end within %0d cycles", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== src/sdio_data_control.sv ====
`timescale 1ns/1ps

module sdio_data_control
  import sdio_data_pkg::*;
(
  input  logic               sdio_clk,
  input  logic               rst,

  // transfer setup
  input  logic               i_activate,
  input  logic               i_block_mode,
  input  logic               i_inc_addr,
  input  logic [ADDR_W-1:0]  i_cmd_address,
  input  logic [CNT_W-1:0]   i_data_cnt,
  input  logic [2:0]         i_func_sel,
  input  logic               i_mem_sel,

  // data phy
  input  logic               i_phy_wr_stb,
  input  logic [BYTE_W-1:0]  i_phy_wr_data,
  output logic               o_phy_rd_stb,
  output logic [BYTE_W-1:0]  o_phy_rd_data,
  output logic               o_phy_com_rdy,

  // cia, functions and memory
  output func_down_t         o_func_down [NUM_TARGETS],
  input  func_up_t           i_func_up [NUM_TARGETS],

  output logic [ADDR_W-1:0]  o_address,
  output logic [TOTAL_W-1:0] o_total_data_cnt,
  output logic               o_finished
);

  xfer_cfg_t cfg;
  logic      data_rdy;
  logic      byte_stb;

  sdio_xfer_config u_config (
    .sdio_clk      (sdio_clk),
    .rst           (rst),
    .i_activate    (i_activate),
    .i_block_mode  (i_block_mode),
    .i_inc_addr    (i_inc_addr),
    .i_cmd_address (i_cmd_address),
    .i_data_cnt    (i_data_cnt),
    .i_func_sel    (i_func_sel),
    .i_mem_sel     (i_mem_sel),
    .o_cfg         (cfg)
  );

  sdio_xfer_sequencer u_sequencer (
    .sdio_clk         (sdio_clk),
    .rst              (rst),
    .i_activate       (i_activate),
    .i_cfg            (cfg),
    .i_byte_stb       (byte_stb),
    .o_data_rdy       (data_rdy),
    .o_address        (o_address),
    .o_total_data_cnt (o_total_data_cnt),
    .o_finished       (o_finished)
  );

  sdio_func_router u_router (
    .i_cfg         (cfg),
    .i_activate    (i_activate),
    .i_data_rdy    (data_rdy),
    .i_phy_wr_stb  (i_phy_wr_stb),
    .i_phy_wr_data (i_phy_wr_data),
    .o_phy_rd_stb  (o_phy_rd_stb),
    .o_phy_rd_data (o_phy_rd_data),
    .o_phy_com_rdy (o_phy_com_rdy),
    .o_func_down   (o_func_down),
    .i_func_up     (i_func_up),
    .o_byte_stb    (byte_stb)
  );

endmodule

// ==== src/sdio_func_router.sv ====
`timescale 1ns/1ps

module sdio_func_router
  import sdio_data_pkg::*;
(
  input  xfer_cfg_t         i_cfg,
  input  logic              i_activate,
  input  logic              i_data_rdy,

  // phy side
  input  logic              i_phy_wr_stb,
  input  logic [BYTE_W-1:0] i_phy_wr_data,
  output logic              o_phy_rd_stb,
  output logic [BYTE_W-1:0] o_phy_rd_data,
  output logic              o_phy_com_rdy,

  // target side
  output func_down_t        o_func_down [NUM_TARGETS],
  input  func_up_t          i_func_up [NUM_TARGETS],

  // byte moved in either direction
  output logic              o_byte_stb
);

  logic sel_valid;
  logic sel_wr_stb;

  // downstream, only the selected target sees anything
  always_comb begin
    for (int i = 0; i < NUM_TARGETS; i++) begin
      o_func_down[i] = '0;
      if (i_cfg.target == target_idx_t'(i)) begin
        o_func_down[i].wr_stb   = i_phy_wr_stb;
        o_func_down[i].wr_data  = i_phy_wr_data;
        o_func_down[i].hst_rdy  = i_data_rdy;
        o_func_down[i].activate = i_activate;
      end
    end
  end

  // upstream mux from the selected target
  always_comb begin
    sel_valid     = 1'b0;
    o_phy_rd_stb  = 1'b0;
    o_phy_rd_data = '0;
    o_phy_com_rdy = 1'b0;
    for (int i = 0; i < NUM_TARGETS; i++) begin
      if (i_cfg.target == target_idx_t'(i)) begin
        sel_valid     = 1'b1;
        o_phy_rd_stb  = i_func_up[i].rd_stb;
        o_phy_rd_data = i_func_up[i].rd_data;
        // card ready only counts while the sequencer takes data
        o_phy_com_rdy = i_func_up[i].com_rdy & i_data_rdy;
      end
    end
  end

  // index 9..15 reaches no target, so its writes are not counted
  assign sel_wr_stb = sel_valid & i_phy_wr_stb;
  assign o_byte_stb = sel_wr_stb | o_phy_rd_stb;

endmodule

// ==== src/sdio_xfer_sequencer.sv ====
`timescale 1ns/1ps

module sdio_xfer_sequencer
  import sdio_data_pkg::*;
(
  input  logic               sdio_clk,
  input  logic               rst,

  input  logic               i_activate,
  input  xfer_cfg_t          i_cfg,
  input  logic               i_byte_stb,

  output logic               o_data_rdy,
  output logic [ADDR_W-1:0]  o_address,
  output logic [TOTAL_W-1:0] o_total_data_cnt,
  output logic               o_finished
);

  seq_state_t         state;
  logic [TOTAL_W-1:0] byte_cnt;
  logic [TOTAL_W-1:0] block_cnt;
  logic               last_byte;
  logic               more_blocks;

  // the strobe about to be counted completes the block
  assign last_byte = i_byte_stb && (byte_cnt == o_total_data_cnt - 1'b1);

  // block_cnt already counts the block in flight
  assign more_blocks = i_cfg.block_mode && (block_cnt < i_cfg.total);

  assign o_finished = (state == ST_FINISHED);

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      state            <= ST_IDLE;
      byte_cnt         <= '0;
      block_cnt        <= '0;
      o_data_rdy       <= 1'b0;
      o_address        <= '0;
      o_total_data_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          byte_cnt         <= '0;
          block_cnt        <= '0;
          o_data_rdy       <= 1'b0;
          o_total_data_cnt <= '0;
          if (i_activate) begin
            state <= ST_CONFIG;
          end
        end

        ST_CONFIG: begin
          byte_cnt <= '0;
          // first pass of a transfer, config is valid from here on
          if (block_cnt == '0) begin
            o_address <= i_cfg.start_addr;
          end
          if (i_cfg.block_mode) begin
            o_total_data_cnt <= TOTAL_W'(BLOCK_BYTES);
            block_cnt        <= block_cnt + 1'b1;
          end else begin
            o_total_data_cnt <= i_cfg.total;
          end
          state <= ST_ACTIVE;
        end

        ST_ACTIVE: begin
          if (byte_cnt < o_total_data_cnt) begin
            o_data_rdy <= 1'b1;
            if (i_byte_stb) begin
              byte_cnt <= byte_cnt + 1'b1;
              if (i_cfg.inc_addr) begin
                o_address <= o_address + 1'b1;
              end
            end
            // close the window on the last byte so no extra byte slips in
            if (last_byte) begin
              o_data_rdy <= 1'b0;
            end
          end else begin
            o_data_rdy <= 1'b0;
            if (more_blocks) begin
              state <= ST_CONFIG;
            end else begin
              state <= ST_FINISHED;
            end
          end
        end

        ST_FINISHED: begin
          o_data_rdy <= 1'b0;
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase

      // activate low cancels or closes the transfer
      if (!i_activate) begin
        state      <= ST_IDLE;
        o_data_rdy <= 1'b0;
      end
    end
  end

endmodule

// ==== src/sdio_xfer_config.sv ====
`timescale 1ns/1ps

module sdio_xfer_config
  import sdio_data_pkg::*;
(
  input  logic              sdio_clk,
  input  logic              rst,

  input  logic              i_activate,
  input  logic              i_block_mode,
  input  logic              i_inc_addr,
  input  logic [ADDR_W-1:0] i_cmd_address,
  input  logic [CNT_W-1:0]  i_data_cnt,
  input  logic [2:0]        i_func_sel,
  input  logic              i_mem_sel,

  output xfer_cfg_t         o_cfg
);

  logic      captured;
  xfer_cfg_t next_cfg;

  // setup as seen on the inputs right now
  always_comb begin
    next_cfg.block_mode = i_block_mode;
    next_cfg.inc_addr   = i_inc_addr;
    next_cfg.start_addr = i_cmd_address;

    // a count of zero means 512 bytes or 512 blocks
    if (i_data_cnt == '0) begin
      next_cfg.total = TOTAL_W'(BLOCK_BYTES);
    end else begin
      next_cfg.total = TOTAL_W'(i_data_cnt);
    end

    // memory select overrides the function number
    if (i_mem_sel) begin
      next_cfg.target = target_idx_t'(MEM_TARGET);
    end else begin
      next_cfg.target = target_idx_t'(i_func_sel);
    end
  end

  // follows the inputs while no transfer runs,
  // the first edge with activate high freezes it
  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      captured <= 1'b0;
      o_cfg    <= '0;
    end else begin
      if (!captured) begin
        o_cfg <= next_cfg;
      end
      // flag stays set for the whole transfer
      captured <= i_activate;
    end
  end

endmodule

// ==== src/sdio_data_pkg.sv ====
package sdio_data_pkg;

  // data path widths
  localparam int BYTE_W  = 8;
  localparam int ADDR_W  = 18;
  localparam int CNT_W   = 9;
  // wide enough to hold 512
  localparam int TOTAL_W = 10;

  // block size, also what a zero count stands for
  localparam int BLOCK_BYTES = 512;

  // cia, functions 1..7 and memory
  localparam int NUM_TARGETS = 9;
  localparam int MEM_TARGET  = 8;

  typedef logic [3:0] target_idx_t;

  // controller to target
  typedef struct packed {
    logic              wr_stb;
    logic [BYTE_W-1:0] wr_data;
    logic              hst_rdy;
    logic              activate;
  } func_down_t;

  // target to controller
  typedef struct packed {
    logic              rd_stb;
    logic [BYTE_W-1:0] rd_data;
    logic              com_rdy;
  } func_up_t;

  // transfer setup, total already has the zero rule applied
  typedef struct packed {
    logic               block_mode;
    logic               inc_addr;
    logic [ADDR_W-1:0]  start_addr;
    logic [TOTAL_W-1:0] total;
    target_idx_t        target;
  } xfer_cfg_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CONFIG,
    ST_ACTIVE,
    ST_FINISHED
  } seq_state_t;

endpackage
